// File: include/dbg_defs.svh
`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

// Datapath widths
`define DBG_WORD_W          32
`define DBG_BYTE_W          8

// Processor state visible to the dump
`define DBG_NUM_REGS        32
`define DBG_NUM_DMEM        16
`define DBG_IMEM_ADDR_W     8
`define DBG_REG_ADDR_W      5
`define DBG_DMEM_ADDR_W     4

// Last instruction of every program
`define DBG_HALT_WORD       32'hFFFF_FFFF

// Command bytes from the host
`define DBG_CH_CONT         8'h63       // 'c'
`define DBG_CH_STEP         8'h73       // 's'
`define DBG_CH_LOAD         8'h64       // 'd'
`define DBG_CH_NEXT         8'h6E       // 'n'

`endif

// File: hdl/dbg_pkg.sv
`include "dbg_defs.svh"

package dbg_pkg;

    typedef enum logic [`DBG_BYTE_W-1:0] {
        CMD_CONT = `DBG_CH_CONT,
        CMD_STEP = `DBG_CH_STEP,
        CMD_LOAD = `DBG_CH_LOAD,
        CMD_NEXT = `DBG_CH_NEXT
    } dbg_cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        RUN,
        STEP_WAIT,
        STEP_PULSE,
        LOAD,
        DUMP
    } dbg_state_e;

    // Order of the words in a dump
    typedef enum logic [2:0] {
        SRC_PC,
        SRC_CYCLES,
        SRC_REGS,
        SRC_DMEM,
        SRC_DONE
    } dump_src_e;

    typedef struct packed {
        logic [`DBG_WORD_W-1:0] pc;
        logic [`DBG_WORD_W-1:0] cycle_count;
        logic [`DBG_WORD_W-1:0] reg_data;       // Register at reg_addr
        logic [`DBG_WORD_W-1:0] dmem_data;      // Data word at dmem_addr
        logic                   halt;
    } cpu_status_t;

    typedef struct packed {
        logic [`DBG_REG_ADDR_W-1:0]  reg_addr;
        logic [`DBG_DMEM_ADDR_W-1:0] dmem_addr;
    } cpu_sel_t;

    typedef struct packed {
        logic                        we;
        logic [`DBG_IMEM_ADDR_W-1:0] addr;      // Byte address
        logic [`DBG_WORD_W-1:0]      data;
    } imem_wr_t;

endpackage

// File: hdl/dbg_control.sv
`include "dbg_defs.svh"

module dbg_control
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_rx_valid,
    input  logic [`DBG_BYTE_W-1:0] i_rx_data,
    input  logic                   i_halt,
    input  logic                   i_load_done,
    input  logic                   i_dump_done,
    output logic                   o_rx_ack,
    output logic [`DBG_BYTE_W-1:0] o_rx_byte,
    output logic                   o_load_strobe,
    output logic                   o_dump_start,
    output logic                   o_cpu_run
);

    import dbg_pkg::*;

    dbg_state_e state;
    dbg_cmd_e   cmd;
    logic       step_mode;      // Return to STEP_WAIT after a dump
    logic       accept;

    // Only IDLE, STEP_WAIT and LOAD take bytes; the rest back-pressure the receiver
    assign accept = i_rx_valid && !o_rx_ack &&
                    (state == IDLE || state == STEP_WAIT ||
                     (state == LOAD && !i_load_done));

    assign cmd = dbg_cmd_e'(i_rx_data);

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state         <= IDLE;
            step_mode     <= 1'b0;
            o_rx_ack      <= 1'b0;
            o_load_strobe <= 1'b0;
            o_dump_start  <= 1'b0;
            o_cpu_run     <= 1'b0;
        end
        else
        begin
            o_rx_ack      <= accept;    // One-cycle acknowledge
            o_load_strobe <= 1'b0;
            o_dump_start  <= 1'b0;

            case (state)
                IDLE:
                begin
                    if (accept)
                    begin
                        case (cmd)
                            CMD_CONT:
                            begin
                                step_mode <= 1'b0;
                                state     <= RUN;
                            end
                            CMD_STEP:
                            begin
                                step_mode <= 1'b1;
                                state     <= STEP_WAIT;
                            end
                            CMD_LOAD:
                                state <= LOAD;
                            default:
                                state <= IDLE;      // Unknown byte dropped
                        endcase
                    end
                end
                RUN:
                begin
                    if (i_halt)
                    begin
                        o_cpu_run    <= 1'b0;
                        o_dump_start <= 1'b1;
                        state        <= DUMP;
                    end
                    else
                    begin
                        o_cpu_run <= 1'b1;
                    end
                end
                STEP_WAIT:
                begin
                    if (accept && cmd == CMD_NEXT)
                    begin
                        o_cpu_run <= 1'b1;          // High for the STEP_PULSE cycle only
                        state     <= STEP_PULSE;
                    end
                end
                STEP_PULSE:
                begin
                    o_cpu_run    <= 1'b0;
                    o_dump_start <= 1'b1;
                    state        <= DUMP;
                end
                LOAD:
                begin
                    if (i_load_done)
                        state <= IDLE;
                    else if (accept)
                        o_load_strobe <= 1'b1;
                end
                DUMP:
                begin
                    if (i_dump_done)
                        state <= (step_mode && !i_halt) ? STEP_WAIT : IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (accept)
            o_rx_byte <= i_rx_data;
    end

endmodule

// File: hdl/instr_loader.sv
`include "dbg_defs.svh"

module instr_loader
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_load_strobe,
    input  logic [`DBG_BYTE_W-1:0] i_rx_byte,
    output dbg_pkg::imem_wr_t      o_imem_wr,
    output logic                   o_load_done
);

    logic [`DBG_WORD_W-1:0]      shift_reg;
    logic [`DBG_WORD_W-1:0]      word_next;
    logic [1:0]                  byte_cnt;
    logic [`DBG_IMEM_ADDR_W-1:0] next_addr;     // Address of the next write
    logic                        wr_we;
    logic [`DBG_IMEM_ADDR_W-1:0] wr_addr;
    logic [`DBG_WORD_W-1:0]      wr_data;

    // First byte ends up in the top of the word
    assign word_next = {shift_reg[`DBG_WORD_W-`DBG_BYTE_W-1:0], i_rx_byte};

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            byte_cnt    <= 2'd0;
            next_addr   <= '0;
            wr_we       <= 1'b0;
            wr_addr     <= '0;
            o_load_done <= 1'b0;
        end
        else
        begin
            wr_we       <= 1'b0;
            o_load_done <= 1'b0;
            if (i_load_strobe)
            begin
                byte_cnt <= byte_cnt + 2'd1;
                if (byte_cnt == 2'd3)
                begin
                    wr_we   <= 1'b1;
                    wr_addr <= next_addr;
                    if (word_next == `DBG_HALT_WORD)
                    begin
                        next_addr   <= '0;      // Program complete
                        o_load_done <= 1'b1;
                    end
                    else
                    begin
                        next_addr <= next_addr + `DBG_IMEM_ADDR_W'(4);
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_load_strobe)
        begin
            shift_reg <= word_next;
            if (byte_cnt == 2'd3)
                wr_data <= word_next;
        end
    end

    assign o_imem_wr.we   = wr_we;
    assign o_imem_wr.addr = wr_addr;
    assign o_imem_wr.data = wr_data;

endmodule

// File: hdl/dump_sequencer.sv
`include "dbg_defs.svh"

module dump_sequencer
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_dump_start,
    input  dbg_pkg::cpu_status_t   i_status,
    input  logic                   i_word_ready,
    output dbg_pkg::cpu_sel_t      o_sel,
    output logic                   o_word_valid,
    output logic [`DBG_WORD_W-1:0] o_word_data,
    output logic                   o_dump_done
);

    import dbg_pkg::*;

    localparam logic [`DBG_REG_ADDR_W-1:0]  LAST_REG  =
        `DBG_REG_ADDR_W'(`DBG_NUM_REGS - 1);
    localparam logic [`DBG_DMEM_ADDR_W-1:0] LAST_DMEM =
        `DBG_DMEM_ADDR_W'(`DBG_NUM_DMEM - 1);

    dump_src_e                   src;
    logic [`DBG_REG_ADDR_W-1:0]  reg_idx;
    logic [`DBG_DMEM_ADDR_W-1:0] dmem_idx;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            src         <= SRC_DONE;
            reg_idx     <= '0;
            dmem_idx    <= '0;
            o_dump_done <= 1'b0;
        end
        else
        begin
            o_dump_done <= 1'b0;
            if (i_dump_start)
            begin
                src      <= SRC_PC;
                reg_idx  <= '0;
                dmem_idx <= '0;
            end
            else if (i_word_ready)
            begin
                // Advance only once the current word is fully on the line
                case (src)
                    SRC_PC:
                        src <= SRC_CYCLES;
                    SRC_CYCLES:
                        src <= SRC_REGS;
                    SRC_REGS:
                    begin
                        if (reg_idx == LAST_REG)
                        begin
                            reg_idx <= '0;
                            src     <= SRC_DMEM;
                        end
                        else
                        begin
                            reg_idx <= reg_idx + 1'b1;
                        end
                    end
                    SRC_DMEM:
                    begin
                        if (dmem_idx == LAST_DMEM)
                        begin
                            dmem_idx    <= '0;
                            src         <= SRC_DONE;
                            o_dump_done <= 1'b1;
                        end
                        else
                        begin
                            dmem_idx <= dmem_idx + 1'b1;
                        end
                    end
                    default:
                        src <= SRC_DONE;
                endcase
            end
        end
    end

    always_comb
    begin
        case (src)
            SRC_PC:     o_word_data = i_status.pc;
            SRC_CYCLES: o_word_data = i_status.cycle_count;
            SRC_REGS:   o_word_data = i_status.reg_data;
            SRC_DMEM:   o_word_data = i_status.dmem_data;
            default:    o_word_data = '0;
        endcase
    end

    assign o_word_valid    = (src != SRC_DONE);
    assign o_sel.reg_addr  = reg_idx;
    assign o_sel.dmem_addr = dmem_idx;

endmodule

// File: hdl/word_serializer.sv
`include "dbg_defs.svh"

module word_serializer
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_word_valid,
    input  logic [`DBG_WORD_W-1:0] i_word_data,
    input  logic                   i_tx_done,
    output logic                   o_word_ready,
    output logic                   o_tx_start,
    output logic [`DBG_BYTE_W-1:0] o_tx_data
);

    logic [`DBG_WORD_W-1:0] shift_reg;
    logic [1:0]             byte_cnt;
    logic                   busy;       // Word held
    logic                   sending;    // Current byte started
    logic                   load_word;
    logic                   byte_end;

    // Skip the ready cycle so the old word is not taken twice
    assign load_word = i_word_valid && !busy && !o_word_ready;
    assign byte_end  = busy && sending && !o_tx_start && i_tx_done;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            busy         <= 1'b0;
            sending      <= 1'b0;
            byte_cnt     <= 2'd0;
            o_tx_start   <= 1'b0;
            o_word_ready <= 1'b0;
        end
        else
        begin
            o_word_ready <= 1'b0;
            if (load_word)
            begin
                busy     <= 1'b1;
                sending  <= 1'b0;
                byte_cnt <= 2'd0;
            end
            else if (busy && !sending)
            begin
                if (i_tx_done)
                begin
                    o_tx_start <= 1'b1;     // Transmitter idle
                    sending    <= 1'b1;
                end
            end
            else if (o_tx_start)
            begin
                if (!i_tx_done)
                    o_tx_start <= 1'b0;     // Byte taken
            end
            else if (byte_end)
            begin
                sending  <= 1'b0;
                byte_cnt <= byte_cnt + 2'd1;
                if (byte_cnt == 2'd3)
                begin
                    busy         <= 1'b0;
                    o_word_ready <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (load_word)
            shift_reg <= i_word_data;
        else if (byte_end)
            shift_reg <= shift_reg << `DBG_BYTE_W;     // Next byte to the top
    end

    assign o_tx_data = shift_reg[`DBG_WORD_W-1 -: `DBG_BYTE_W];

endmodule

// File: hdl/dbg_top.sv
`include "dbg_defs.svh"

module dbg_top
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_rx_valid,
    input  logic [`DBG_BYTE_W-1:0] i_rx_data,
    output logic                   o_rx_ack,
    output logic                   o_tx_start,
    output logic [`DBG_BYTE_W-1:0] o_tx_data,
    input  logic                   i_tx_done,
    input  dbg_pkg::cpu_status_t   i_cpu_status,
    output dbg_pkg::cpu_sel_t      o_cpu_sel,
    output dbg_pkg::imem_wr_t      o_imem_wr,
    output logic                   o_cpu_run
);

    logic [`DBG_BYTE_W-1:0] rx_byte;
    logic                   load_strobe;
    logic                   load_done;
    logic                   dump_start;
    logic                   dump_done;
    logic                   word_valid;
    logic [`DBG_WORD_W-1:0] word_data;
    logic                   word_ready;

    dbg_control u_control
    (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_rx_valid    (i_rx_valid),
        .i_rx_data     (i_rx_data),
        .i_halt        (i_cpu_status.halt),
        .i_load_done   (load_done),
        .i_dump_done   (dump_done),
        .o_rx_ack      (o_rx_ack),
        .o_rx_byte     (rx_byte),
        .o_load_strobe (load_strobe),
        .o_dump_start  (dump_start),
        .o_cpu_run     (o_cpu_run)
    );

    instr_loader u_loader
    (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_load_strobe (load_strobe),
        .i_rx_byte     (rx_byte),
        .o_imem_wr     (o_imem_wr),
        .o_load_done   (load_done)
    );

    dump_sequencer u_dump
    (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_dump_start  (dump_start),
        .i_status      (i_cpu_status),
        .i_word_ready  (word_ready),
        .o_sel         (o_cpu_sel),
        .o_word_valid  (word_valid),
        .o_word_data   (word_data),
        .o_dump_done   (dump_done)
    );

    word_serializer u_serializer
    (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_word_valid  (word_valid),
        .i_word_data   (word_data),
        .i_tx_done     (i_tx_done),
        .o_word_ready  (word_ready),
        .o_tx_start    (o_tx_start),
        .o_tx_data     (o_tx_data)
    );

endmodule

// File: testbench/dbg_sva.sv
`include "dbg_defs.svh"

module dbg_sva
(
    input logic                        i_clk,
    input logic                        i_reset,
    input logic                        i_rx_ack,
    input logic                        i_tx_start,
    input logic [`DBG_BYTE_W-1:0]      i_tx_data,
    input logic                        i_tx_done,
    input logic                        i_cpu_run,
    input logic                        i_halt,
    input dbg_pkg::cpu_sel_t           i_cpu_sel,
    input dbg_pkg::imem_wr_t           i_imem_wr
);

    int                          fail_count = 0;
    logic [`DBG_IMEM_ADDR_W-1:0] prev_addr;     // Address of the last write

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            prev_addr <= '0;
        else if (i_imem_wr.we)
            prev_addr <= i_imem_wr.addr;
    end

    reset_idle: assert property (@(posedge i_clk)
        i_reset |=> !i_cpu_run && !i_rx_ack && !i_tx_start && !i_imem_wr.we && i_cpu_sel == '0)
    else
    begin
        $error("Outputs not idle after reset");
        fail_count++;
    end

    ack_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        i_rx_ack |=> !i_rx_ack)
    else
    begin
        $error("Receive acknowledge longer than one cycle");
        fail_count++;
    end

    we_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        i_imem_wr.we |=> !i_imem_wr.we)
    else
    begin
        $error("Instruction write enable longer than one cycle");
        fail_count++;
    end

    // A new program starts again at address 0
    addr_step: assert property (@(posedge i_clk) disable iff (i_reset)
        i_imem_wr.we && i_imem_wr.addr != '0 |->
            i_imem_wr.addr == prev_addr + `DBG_IMEM_ADDR_W'(4))
    else
    begin
        $error("Instruction write address did not rise by 4");
        fail_count++;
    end

    // Start is first seen one edge after it was raised
    tx_rise: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_tx_start) |-> $past(i_tx_done))
    else
    begin
        $error("Transmit start raised while the transmitter was busy");
        fail_count++;
    end

    tx_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        i_tx_start |=> $stable(i_tx_data))
    else
    begin
        $error("Transmit data changed during the start handshake");
        fail_count++;
    end

    halt_stop: assert property (@(posedge i_clk) disable iff (i_reset)
        i_cpu_run && i_halt |=> !i_cpu_run)
    else
    begin
        $error("Clock enable still high after halt");
        fail_count++;
    end

    // Step pulse starts together with the acknowledge of 'n'
    step_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_cpu_run) && i_rx_ack |=> !i_cpu_run)
    else
    begin
        $error("Step gave more than one enable cycle");
        fail_count++;
    end

endmodule

bind dbg_top dbg_sva u_sva
(
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_rx_ack   (o_rx_ack),
    .i_tx_start (o_tx_start),
    .i_tx_data  (o_tx_data),
    .i_tx_done  (i_tx_done),
    .i_cpu_run  (o_cpu_run),
    .i_halt     (i_cpu_status.halt),
    .i_cpu_sel  (o_cpu_sel),
    .i_imem_wr  (o_imem_wr)
);

// File: testbench/tb_dbg.sv
`include "dbg_defs.svh"

module tb_dbg;

    import dbg_pkg::*;

    localparam int PROG_WORDS = 5;
    localparam int DUMP_WORDS = 2 + `DBG_NUM_REGS + `DBG_NUM_DMEM;
    localparam int DUMP_BYTES = 4 * DUMP_WORDS;
    localparam int BYTE_WORST = 7;      // Start, up to 4 busy cycles, return, next start
    localparam int WORD_WORST = 3;      // Ready and reload between words
    localparam int RX_WORST   = 10;
    localparam int NUM_DUMPS  = 4;
    localparam int NUM_RX     = 1 + 1 + 4 * (PROG_WORDS + 1) + 1 + 1 + 3;
    localparam int TIMEOUT    = NUM_DUMPS * (DUMP_BYTES * BYTE_WORST + DUMP_WORDS * WORD_WORST)
                                + NUM_RX * RX_WORST + 1000;
    localparam logic [31:0] FIXED_PC = 32'h0000_0140;

    logic                   clk;
    logic                   reset;
    logic                   rx_valid;
    logic [`DBG_BYTE_W-1:0] rx_data;
    logic                   rx_ack;
    logic                   tx_start;
    logic [`DBG_BYTE_W-1:0] tx_data;
    logic                   tx_done;
    cpu_status_t            cpu_status;
    cpu_sel_t               cpu_sel;
    imem_wr_t               imem_wr;
    logic                   cpu_run;
    logic                   halt;
    logic [31:0]            run_cycles;

    logic [7:0]             tx_bytes[$];    // Bytes seen on the transmitter
    logic [7:0]             wr_addr_q[$];
    logic [31:0]            wr_data_q[$];
    logic [31:0]            exp_cycles;
    int                     errors = 0;
    string                  test_name;

    dbg_top dut
    (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_rx_valid   (rx_valid),
        .i_rx_data    (rx_data),
        .o_rx_ack     (rx_ack),
        .o_tx_start   (tx_start),
        .o_tx_data    (tx_data),
        .i_tx_done    (tx_done),
        .i_cpu_status (cpu_status),
        .o_cpu_sel    (cpu_sel),
        .o_imem_wr    (imem_wr),
        .o_cpu_run    (cpu_run)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Processor status, answered from the select addresses
    always_comb
    begin
        cpu_status.pc          = FIXED_PC;
        cpu_status.cycle_count = run_cycles;
        cpu_status.reg_data    = 32'(cpu_sel.reg_addr) * 32'h0101_0101;
        cpu_status.dmem_data   = 32'hA000_0000 + 32'(cpu_sel.dmem_addr);
        cpu_status.halt        = halt;
    end

    always @(posedge clk)
    begin
        if (reset)
            run_cycles <= 32'd0;
        else if (cpu_run)
            run_cycles <= run_cycles + 32'd1;
    end

    always @(negedge clk)
    begin
        if (imem_wr.we)
        begin
            wr_addr_q.push_back(imem_wr.addr);
            wr_data_q.push_back(imem_wr.data);
        end
    end

    initial
    begin : tx_model
        int hold;
        tx_done = 1'b1;
        forever
        begin
            @(negedge clk);
            if (tx_start && tx_done)
            begin
                tx_bytes.push_back(tx_data);
                tx_done = 1'b0;                 // Byte taken
                hold = $urandom_range(4, 1);
                repeat (hold) @(negedge clk);
                tx_done = 1'b1;
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            errors++;
            $display("Error %s, %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_cond(input logic cond, input string msg);
        assert (cond)
        else
        begin
            errors++;
            $display("%s test: %s", test_name, msg);
        end
    endtask

    // Holds the byte until the acknowledge is seen
    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = $urandom_range(3, 1);
        repeat (gap) @(negedge clk);
        rx_data  = b;
        rx_valid = 1'b1;
        do
            @(negedge clk);
        while (!rx_ack);
        rx_valid = 1'b0;
    endtask

    task automatic expect_dump(input logic [31:0] cycles);
        logic [31:0] words[$];
        logic [7:0]  exp_bytes[$];
        logic [7:0]  b;
        int          i;
        int          j;
        words.push_back(FIXED_PC);
        words.push_back(cycles);
        for (i = 0; i < `DBG_NUM_REGS; i++)
            words.push_back(32'(i) * 32'h0101_0101);
        for (i = 0; i < `DBG_NUM_DMEM; i++)
            words.push_back(32'hA000_0000 + 32'(i));
        for (i = 0; i < DUMP_WORDS; i++)
            for (j = 3; j >= 0; j--)
                exp_bytes.push_back(words[i][8*j +: 8]);   // Most significant byte first
        while (tx_bytes.size() < DUMP_BYTES)
        begin
            @(negedge clk);
            check_cond(!cpu_run, "o_cpu_run high during a dump");
        end
        for (i = 0; i < DUMP_BYTES; i++)
        begin
            b = tx_bytes.pop_front();
            check_value($sformatf("dump byte %0d", i), 32'(exp_bytes[i]), 32'(b));
        end
    endtask

    initial
    begin : stimulus
        logic [31:0] prog[PROG_WORDS+1];
        int          run_len;
        int          i;
        int          j;
        void'($urandom(32'h141e_5f42));
        reset      = 1'b1;
        rx_valid   = 1'b0;
        rx_data    = 8'h00;
        halt       = 1'b0;
        exp_cycles = 32'd0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        test_name = "reset";
        check_cond(!cpu_run && !rx_ack && !tx_start && !imem_wr.we, "outputs not low after reset");

        test_name = "unknown byte";
        send_byte(8'h78);
        @(negedge clk);
        check_cond(!rx_ack, "o_rx_ack high for more than one cycle");
        repeat (10)
        begin
            @(negedge clk);
            check_cond(!cpu_run, "o_cpu_run raised by an unknown byte");
        end
        check_value("writes", 32'd0, 32'(wr_addr_q.size()));
        check_value("bytes sent", 32'd0, 32'(tx_bytes.size()));

        test_name = "load";
        for (i = 0; i < PROG_WORDS; i++)
            prog[i] = $urandom() & 32'h7FFF_FFFF;    // Keep clear of the halt word
        prog[PROG_WORDS] = `DBG_HALT_WORD;
        send_byte(`DBG_CH_LOAD);
        for (i = 0; i <= PROG_WORDS; i++)
            for (j = 3; j >= 0; j--)
                send_byte(prog[i][8*j +: 8]);
        while (wr_addr_q.size() < PROG_WORDS + 1)
            @(negedge clk);
        for (i = 0; i <= PROG_WORDS; i++)
        begin
            check_value($sformatf("write %0d address", i), 32'(4 * i), 32'(wr_addr_q[i]));
            check_value($sformatf("write %0d data", i), prog[i], wr_data_q[i]);
        end

        test_name = "run";
        send_byte(`DBG_CH_CONT);
        run_len = $urandom_range(20, 5);
        repeat (run_len)
        begin
            @(negedge clk);
            check_cond(cpu_run, "o_cpu_run low before halt");
        end
        halt       = 1'b1;
        exp_cycles = exp_cycles + 32'(run_len);
        @(negedge clk);
        check_cond(!cpu_run, "o_cpu_run still high after halt");
        expect_dump(exp_cycles);
        halt = 1'b0;

        test_name = "step";
        send_byte(`DBG_CH_STEP);
        repeat (3)
        begin
            send_byte(`DBG_CH_NEXT);
            exp_cycles = exp_cycles + 32'd1;        // One enable cycle per step
            expect_dump(exp_cycles);
        end

        test_name = "final";
        repeat (20) @(negedge clk);
        check_value("extra bytes sent", 32'd0, 32'(tx_bytes.size()));
        check_value("total writes", 32'(PROG_WORDS + 1), 32'(wr_addr_q.size()));

        $display("Summary: %0d scoreboard errors, %0d assertion failures",
                 errors, dut.u_sva.fail_count);
        if (errors == 0 && dut.u_sva.fail_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles, %0d scoreboard errors",
                 TIMEOUT, errors);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: list.f
+incdir+include
hdl/dbg_pkg.sv
hdl/dbg_control.sv
hdl/instr_loader.sv
hdl/dump_sequencer.sv
hdl/word_serializer.sv
hdl/dbg_top.sv
testbench/dbg_sva.sv
testbench/tb_dbg.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --timing --assert
TOP        = tb_dbg
FILELIST   = list.f
BUILD_DIR  = obj_dir
LOG        = sim.log
SIM_ARGS   = +verilator+error+limit+100
PASS_TEXT  = All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
